/* source/xif_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Issue-port types of the coprocessor interface. Only the issue
// channel is modelled, so no result or commit types exist here
//////////////////////////////////////////////////////////////////////
package xif_pkg;

  // Raw instruction word as offered by the processor
  typedef logic [31:0] instr_t;

  // One source register value
  typedef logic [31:0] reg_t;

  // Issue request, rs[0] to rs[2] map to rs1 to rs3
  typedef struct packed {
    instr_t     instr;
    reg_t [2:0] rs;
    logic       rs_valid;  // All source operands are present
  } issue_req_t;

  // Issue response
  typedef struct packed {
    logic accept;    // Instruction is handled by the coprocessor
    logic dualread;  // Always low, no 64-bit operands
  } issue_rsp_t;

endpackage

/* source/accel_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator types, register map and tile descriptor. Matrix
// sizes are 16 bit, elements are 2 bytes wide
//////////////////////////////////////////////////////////////////////
package accel_pkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [15:0] size_t;
  typedef logic [2:0]  op_t;      // Instruction bits 9:7
  typedef logic [2:0]  fmt_t;     // Instruction bits 12:10
  typedef logic [2:0]  cfg_idx_t;

  // Custom opcodes
  localparam opcode_t OPC_MCNFIG = 7'h0B;
  localparam opcode_t OPC_MARITH = 7'h2B;

  localparam int unsigned NUM_CFG_REGS = 6;

  // Order of the configuration words on the register bus
  localparam cfg_idx_t CFG_X     = 3'd0;
  localparam cfg_idx_t CFG_W     = 3'd1;
  localparam cfg_idx_t CFG_Z     = 3'd2;
  localparam cfg_idx_t CFG_MK    = 3'd3;  // M in bits 15:0, K in bits 31:16
  localparam cfg_idx_t CFG_N     = 3'd4;
  localparam cfg_idx_t CFG_INSTR = 3'd5;

  // Register map, one word every 4 bytes from CFG_BASE
  localparam addr_t CFG_BASE     = 32'h40;
  localparam addr_t TRIGGER_ADDR = 32'h0;

  localparam int unsigned ELEM_BYTES = 2;

  // Register bus request, write only in this design
  typedef struct packed {
    logic       req;
    logic       wen;   // Low means write
    logic [3:0] be;
    addr_t      add;
    logic [3:0] id;
    data_t      data;
  } regbus_req_t;

  typedef struct packed {
    logic gnt;
  } regbus_rsp_t;

  // One job as seen by the scheduler
  typedef struct packed {
    addr_t x;
    addr_t w;
    addr_t z;
    size_t m;
    size_t k;
    size_t n;
    op_t   op;
    fmt_t  fmt;
  } job_cfg_t;

  // One output tile
  typedef struct packed {
    addr_t x_addr;
    addr_t w_addr;
    addr_t z_addr;
    size_t rows;
    size_t cols;
    op_t   op;
    fmt_t  fmt;
  } tile_desc_t;

endpackage

/* source/inst_decoder.sv */
//////////////////////////////////////////////////////////////////////
// Takes the config and arith instructions and writes the six words
// plus the trigger over the register bus. Arith waits while busy
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module inst_decoder
  import xif_pkg::*;
  import accel_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  logic        issue_valid_i,
  input  issue_req_t  issue_req_i,
  output logic        issue_ready_o,
  output issue_rsp_t  issue_rsp_o,
  output regbus_req_t regbus_req_o,
  input  regbus_rsp_t regbus_rsp_i,
  input  logic        cfg_complete_i,
  output logic        start_cfg_o
);

  typedef enum logic [1:0] {Idle, WriteCfg, Trigger} state_e;

  state_e                   state_q, state_d;
  opcode_t                  opcode;
  logic                     is_cfg, is_arith;
  logic                     take, load_size, load_arith;
  data_t [NUM_CFG_REGS-1:0] cfg_q;
  cfg_idx_t                 word_q;
  logic                     word_inc, word_rst;
  size_t                    size_m, size_k;

  assign opcode   = opcode_t'(issue_req_i.instr[6:0]);
  assign is_cfg   = (opcode == OPC_MCNFIG);
  assign is_arith = (opcode == OPC_MARITH);

  // Arith only while no configuration sequence is in flight
  always_comb begin
    issue_ready_o = 1'b0;
    issue_rsp_o   = '0;
    if (issue_valid_i && !clear_i) begin
      if (is_cfg || (is_arith && state_q == Idle)) begin
        issue_ready_o      = 1'b1;
        issue_rsp_o.accept = 1'b1;
      end
    end
  end

  assign take       = issue_valid_i & issue_ready_o;
  assign load_size  = take & is_cfg;
  assign load_arith = take & is_arith & issue_req_i.rs_valid;

  // rs1 of the config instruction packs M low and K high
  assign size_m = size_t'(issue_req_i.rs[0][15:0]);
  assign size_k = size_t'(issue_req_i.rs[0][31:16]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (clear_i) begin
      cfg_q <= '0;
    end else begin
      if (load_size) begin
        cfg_q[CFG_MK] <= {size_k, size_m};
        cfg_q[CFG_N]  <= issue_req_i.rs[1];  // N size
      end
      if (load_arith) begin
        cfg_q[CFG_X]     <= issue_req_i.rs[0];
        cfg_q[CFG_W]     <= issue_req_i.rs[1];
        cfg_q[CFG_Z]     <= issue_req_i.rs[2];
        cfg_q[CFG_INSTR] <= issue_req_i.instr;  // Carries op and format
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (clear_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Index of the word currently on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
    end else if (clear_i || word_rst) begin
      word_q <= '0;
    end else if (word_inc) begin
      word_q <= word_q + cfg_idx_t'(1);
    end
  end

  always_comb begin
    state_d      = state_q;
    word_inc     = 1'b0;
    word_rst     = 1'b0;
    start_cfg_o  = 1'b0;
    regbus_req_o = '0;

    case (state_q)
      Idle: begin
        if (load_arith) state_d = WriteCfg;
      end

      WriteCfg: begin
        regbus_req_o.req  = 1'b1;
        regbus_req_o.wen  = 1'b0;
        regbus_req_o.be   = 4'hF;
        regbus_req_o.add  = CFG_BASE + (addr_t'(word_q) << 2);
        regbus_req_o.data = cfg_q[word_q];
        if (regbus_rsp_i.gnt) begin
          word_inc = 1'b1;
          if (word_q == cfg_idx_t'(NUM_CFG_REGS - 1)) begin
            word_rst    = 1'b1;
            start_cfg_o = 1'b1;  // Last word granted
            state_d     = Trigger;
          end
        end
      end

      Trigger: begin
        // Write to the trigger register once the file has all words
        if (cfg_complete_i) begin
          regbus_req_o.req = 1'b1;
          regbus_req_o.wen = 1'b0;
          regbus_req_o.be  = 4'hF;
          regbus_req_o.add = TRIGGER_ADDR;
          if (regbus_rsp_i.gnt) state_d = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

endmodule

/* source/ctrl_regfile.sv */
//////////////////////////////////////////////////////////////////////
// Write-only register file. Reads are not supported, writes outside
// the map are granted and dropped. Trigger waits for an idle scheduler
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ctrl_regfile
  import accel_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  regbus_req_t regbus_req_i,
  output regbus_rsp_t regbus_rsp_o,
  input  logic        start_cfg_i,
  input  logic        sched_busy_i,
  output logic        cfg_complete_o,
  output logic        job_start_o,
  output job_cfg_t    job_cfg_o
);

  data_t [NUM_CFG_REGS-1:0] cfg_q;
  logic  [NUM_CFG_REGS-1:0] written_q, written_d, cfg_hit;
  addr_t                    cfg_off;
  cfg_idx_t                 cfg_idx;
  logic                     wr_req, cfg_sel, trig_sel, trig_fire;
  logic                     cfg_complete_q, job_start_q;

  assign wr_req  = regbus_req_i.req & ~regbus_req_i.wen;
  assign cfg_off = regbus_req_i.add - CFG_BASE;
  assign cfg_idx = cfg_off[2 +: $bits(cfg_idx_t)];

  assign cfg_sel  = wr_req && (regbus_req_i.add >= CFG_BASE) &&
                    (cfg_off < addr_t'(NUM_CFG_REGS * 4));
  assign trig_sel = wr_req && (regbus_req_i.add == TRIGGER_ADDR);

  // Only the trigger sees back-pressure
  assign regbus_rsp_o.gnt = regbus_req_i.req & ~(trig_sel & sched_busy_i);
  assign trig_fire        = trig_sel & ~sched_busy_i;

  always_comb begin
    cfg_hit = '0;
    if (cfg_sel) cfg_hit[cfg_idx] = 1'b1;
  end

  // Includes the word written in this cycle
  assign written_d = written_q | cfg_hit;

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      cfg_q <= '0;
    end else if (cfg_sel) begin
      for (int b = 0; b < 4; b++) begin
        if (regbus_req_i.be[b]) cfg_q[cfg_idx][8*b +: 8] <= regbus_req_i.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q      <= '0;
      cfg_complete_q <= 1'b0;
      job_start_q    <= 1'b0;
    end else if (clear_i) begin
      written_q      <= '0;
      cfg_complete_q <= 1'b0;
      job_start_q    <= 1'b0;
    end else begin
      job_start_q <= trig_fire;
      if (trig_fire) begin
        written_q      <= '0;  // Next job needs a full set again
        cfg_complete_q <= 1'b0;
      end else begin
        written_q <= written_d;
        if (start_cfg_i && (&written_d)) cfg_complete_q <= 1'b1;
      end
    end
  end

  assign cfg_complete_o = cfg_complete_q;
  assign job_start_o    = job_start_q;

  // Words decoded into job fields
  always_comb begin
    job_cfg_o.x   = cfg_q[CFG_X];
    job_cfg_o.w   = cfg_q[CFG_W];
    job_cfg_o.z   = cfg_q[CFG_Z];
    job_cfg_o.m   = size_t'(cfg_q[CFG_MK][15:0]);
    job_cfg_o.k   = size_t'(cfg_q[CFG_MK][31:16]);
    job_cfg_o.n   = size_t'(cfg_q[CFG_N][15:0]);
    job_cfg_o.op  = op_t'(cfg_q[CFG_INSTR][9:7]);
    job_cfg_o.fmt = fmt_t'(cfg_q[CFG_INSTR][12:10]);
  end

endmodule

/* source/tile_scheduler.sv */
//////////////////////////////////////////////////////////////////////
// Walks the output in TILE_M x TILE_N tiles, column tiles fastest,
// one descriptor per cycle. A new job is only taken while idle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tile_scheduler
  import accel_pkg::*;
#(
  parameter int unsigned TILE_M = 4,
  parameter int unsigned TILE_N = 8
)(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       job_start_i,
  input  job_cfg_t   job_cfg_i,
  output logic       busy_o,
  output logic       tile_valid_o,
  output tile_desc_t tile_o,
  output logic       job_done_o
);

  localparam size_t TM     = size_t'(TILE_M);
  localparam size_t TN     = size_t'(TILE_N);
  localparam addr_t W_STEP = addr_t'(TILE_N * ELEM_BYTES);  // Next column tile
  localparam addr_t R_MUL  = addr_t'(TILE_M * ELEM_BYTES);

  job_cfg_t    job_q;
  addr_t       x_cur, w_cur, z_row, z_cur;
  addr_t       x_step_q, z_step_q;
  size_t       row_base, col_base;
  size_t       rem_m, rem_n;
  logic [16:0] row_next, col_next;
  logic        last_row, last_col;
  logic        busy_q, empty_q;
  logic        job_empty;

  assign job_empty = (job_cfg_i.m == '0) || (job_cfg_i.n == '0);

  assign row_next = {1'b0, row_base} + {1'b0, TM};
  assign col_next = {1'b0, col_base} + {1'b0, TN};
  assign last_row = (row_next >= {1'b0, job_q.m});
  assign last_col = (col_next >= {1'b0, job_q.n});

  // Remaining extent, clipped at the matrix edge
  assign rem_m = job_q.m - row_base;
  assign rem_n = job_q.n - col_base;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      empty_q <= 1'b0;
    end else if (clear_i) begin
      busy_q  <= 1'b0;
      empty_q <= 1'b0;
    end else begin
      empty_q <= job_start_i & ~busy_o & job_empty;
      if (job_start_i && !busy_o) begin
        busy_q <= ~job_empty;
      end else if (busy_q && last_row && last_col) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Running address updates
  always_ff @(posedge clk_i) begin
    if (job_start_i && !busy_o) begin
      job_q    <= job_cfg_i;
      x_cur    <= job_cfg_i.x;
      w_cur    <= job_cfg_i.w;
      z_row    <= job_cfg_i.z;
      z_cur    <= job_cfg_i.z;
      row_base <= '0;
      col_base <= '0;
      x_step_q <= addr_t'(job_cfg_i.k) * R_MUL;  // TILE_M rows of X
      z_step_q <= addr_t'(job_cfg_i.n) * R_MUL;  // TILE_M rows of Z
    end else if (busy_q) begin
      if (last_col) begin
        col_base <= '0;
        w_cur    <= job_q.w;
        row_base <= row_base + TM;
        x_cur    <= x_cur + x_step_q;
        z_row    <= z_row + z_step_q;
        z_cur    <= z_row + z_step_q;  // Start of the next row tile
      end else begin
        col_base <= col_base + TN;
        w_cur    <= w_cur + W_STEP;
        z_cur    <= z_cur + W_STEP;
      end
    end
  end

  always_comb begin
    tile_o.x_addr = x_cur;
    tile_o.w_addr = w_cur;
    tile_o.z_addr = z_cur;
    tile_o.rows   = (rem_m < TM) ? rem_m : TM;
    tile_o.cols   = (rem_n < TN) ? rem_n : TN;
    tile_o.op     = job_q.op;
    tile_o.fmt    = job_q.fmt;
  end

  assign tile_valid_o = busy_q;
  assign job_done_o   = (busy_q & last_row & last_col) | empty_q;
  assign busy_o       = busy_q | empty_q;  // Empty job still owes its done pulse

endmodule

/* source/accel_top.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator front end. Tile sizes are set here and passed down
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module accel_top
  import xif_pkg::*;
  import accel_pkg::*;
#(
  parameter int unsigned TILE_M = 4,
  parameter int unsigned TILE_N = 8
)(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       issue_valid_i,
  input  issue_req_t issue_req_i,
  output logic       issue_ready_o,
  output issue_rsp_t issue_rsp_o,
  output logic       tile_valid_o,
  output tile_desc_t tile_o,
  output logic       job_done_o,
  output logic       busy_o
);

  regbus_req_t regbus_req;
  regbus_rsp_t regbus_rsp;
  logic        start_cfg, cfg_complete;
  logic        job_start, sched_busy;
  job_cfg_t    job_cfg;

  inst_decoder u_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .issue_valid_i  (issue_valid_i),
    .issue_req_i    (issue_req_i),
    .issue_ready_o  (issue_ready_o),
    .issue_rsp_o    (issue_rsp_o),
    .regbus_req_o   (regbus_req),
    .regbus_rsp_i   (regbus_rsp),
    .cfg_complete_i (cfg_complete),
    .start_cfg_o    (start_cfg)
  );

  ctrl_regfile u_regfile (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .regbus_req_i   (regbus_req),
    .regbus_rsp_o   (regbus_rsp),
    .start_cfg_i    (start_cfg),
    .sched_busy_i   (sched_busy),
    .cfg_complete_o (cfg_complete),
    .job_start_o    (job_start),
    .job_cfg_o      (job_cfg)
  );

  tile_scheduler #(
    .TILE_M (TILE_M),
    .TILE_N (TILE_N)
  ) u_scheduler (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .job_start_i  (job_start),
    .job_cfg_i    (job_cfg),
    .busy_o       (sched_busy),
    .tile_valid_o (tile_valid_o),
    .tile_o       (tile_o),
    .job_done_o   (job_done_o)
  );

  assign busy_o = sched_busy;

endmodule

/* tests/tb_model.svh */
//////////////////////////////////////////////////////////////////////
// Expected tile list of one job and instruction encoders. Included
// inside tb_accel, uses its TILE_M, TILE_N and queues
//////////////////////////////////////////////////////////////////////
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Arith instruction, op in bits 9:7 and format in bits 12:10
function automatic instr_t encode_arith(input op_t op, input fmt_t fmt);
  return {19'h0, fmt, op, OPC_MARITH};
endfunction

function automatic instr_t encode_config();
  return {25'h0, OPC_MCNFIG};
endfunction

// Appends the descriptors of one job, column tiles fastest
function automatic void build_expected(input addr_t x, input addr_t w, input addr_t z,
                                       input size_t m, input size_t k, input size_t n,
                                       input instr_t instr);
  tile_desc_t d;
  int         tiles;
  int         rem_m;
  int         rem_n;
  tiles = 0;
  for (int i = 0; i * TILE_M < int'(m); i++) begin
    for (int j = 0; j * TILE_N < int'(n); j++) begin
      rem_m    = int'(m) - i * TILE_M;
      rem_n    = int'(n) - j * TILE_N;
      d.x_addr = x + addr_t'(i * TILE_M * int'(k) * ELEM_BYTES);
      d.w_addr = w + addr_t'(j * TILE_N * ELEM_BYTES);
      d.z_addr = z + addr_t'((i * TILE_M * int'(n) + j * TILE_N) * ELEM_BYTES);
      d.rows   = size_t'((rem_m < TILE_M) ? rem_m : TILE_M);  // Clipped at the edge
      d.cols   = size_t'((rem_n < TILE_N) ? rem_n : TILE_N);
      d.op     = op_t'(instr[9:7]);
      d.fmt    = fmt_t'(instr[12:10]);
      exp_q.push_back(d);
      tiles++;
    end
  end
  cnt_q.push_back(tiles);  // Zero for an empty job
endfunction

`endif

/* tests/tb_accel.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for accel_top with the default 4 x 8 tiles. Jobs are
// issued over the issue port, descriptors compared at the falling edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_accel
  import xif_pkg::*;
  import accel_pkg::*;
();

  localparam int TILE_M       = 4;
  localparam int TILE_N       = 8;
  localparam int CLK_PERIOD   = 4;
  localparam int NUM_JOBS     = 14;
  localparam int MAX_TILES    = 64;
  localparam int JOB_OVERHEAD = 40;  // Issue, six writes, trigger, idle gaps
  localparam int TIMEOUT_NS   = (NUM_JOBS * (MAX_TILES + JOB_OVERHEAD) + 8) * CLK_PERIOD;

  logic       clk_i;
  logic       rst_ni;
  logic       clear_i;
  logic       issue_valid_i;
  issue_req_t issue_req_i;
  logic       issue_ready_o;
  issue_rsp_t issue_rsp_o;
  logic       tile_valid_o;
  tile_desc_t tile_o;
  logic       job_done_o;
  logic       busy_o;

  tile_desc_t exp_q[$];  // Expected descriptors of all pending jobs
  int         cnt_q[$];  // Descriptors still owed per pending job
  tile_desc_t exp_d;
  logic       last_tile;
  int         jobs_done = 0;
  int         tiles_seen = 0;
  int         seed = 32'h0060_03e4;

  `include "tb_model.svh"

  accel_top dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .issue_valid_i (issue_valid_i),
    .issue_req_i   (issue_req_i),
    .issue_ready_o (issue_ready_o),
    .issue_rsp_o   (issue_rsp_o),
    .tile_valid_o  (tile_valid_o),
    .tile_o        (tile_o),
    .job_done_o    (job_done_o),
    .busy_o        (busy_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      fail_now($sformatf("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want));
  endtask

  function automatic int rand_below(input int lim);
    return int'($unsigned($random(seed)) % lim);
  endfunction

  // Holds the request until the decoder takes it
  task automatic issue_instr(input instr_t instr, input reg_t rs1, input reg_t rs2,
                             input reg_t rs3);
    issue_req_t req;
    logic       taken;
    req.instr    = instr;
    req.rs[0]    = rs1;
    req.rs[1]    = rs2;
    req.rs[2]    = rs3;
    req.rs_valid = 1'b1;
    taken        = 1'b0;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_req_i   <= req;
    while (!taken) begin
      @(negedge clk_i);
      taken = issue_ready_o;
      if (taken) begin
        check_val("issue_rsp_o.accept", 32'(issue_rsp_o.accept), 32'd1);
        check_val("issue_rsp_o.dualread", 32'(issue_rsp_o.dualread), 32'd0);
      end
      @(posedge clk_i);
    end
    issue_valid_i <= 1'b0;
    issue_req_i   <= '0;
  endtask

  task automatic run_job(input size_t m, input size_t k, input size_t n, input addr_t x,
                         input addr_t w, input addr_t z, input instr_t instr);
    issue_instr(encode_config(), {k, m}, 32'(n), 32'd0);
    build_expected(x, w, z, m, k, n, instr);
    issue_instr(instr, x, w, z);
  endtask

  task automatic wait_idle();
    while (cnt_q.size() != 0) @(negedge clk_i);
  endtask

  // Offers a foreign opcode for a few cycles, it must never be taken
  task automatic offer_unknown();
    issue_req_t req;
    req.instr    = {25'h0, 7'h33};
    req.rs[0]    = 32'hdead_0003;
    req.rs[1]    = 32'h0000_0005;
    req.rs[2]    = 32'hbeef_0000;
    req.rs_valid = 1'b1;
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    issue_req_i   <= req;
    repeat (6) begin
      @(negedge clk_i);
      check_val("issue_ready_o", 32'(issue_ready_o), 32'd0);
      check_val("issue_rsp_o.accept", 32'(issue_rsp_o.accept), 32'd0);
    end
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    issue_req_i   <= '0;
  endtask

  // Comparison process
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (tile_valid_o) begin
        assert (exp_q.size() > 0 && cnt_q.size() > 0 && cnt_q[0] > 0) else
          fail_now($sformatf("A descriptor came out at %0t ns with none expected", $time));
        exp_d     = exp_q.pop_front();
        cnt_q[0]  = cnt_q[0] - 1;
        last_tile = (cnt_q[0] == 0);
        check_val("tile_o.x_addr", tile_o.x_addr, exp_d.x_addr);
        check_val("tile_o.w_addr", tile_o.w_addr, exp_d.w_addr);
        check_val("tile_o.z_addr", tile_o.z_addr, exp_d.z_addr);
        check_val("tile_o.rows", 32'(tile_o.rows), 32'(exp_d.rows));
        check_val("tile_o.cols", 32'(tile_o.cols), 32'(exp_d.cols));
        check_val("tile_o.op", 32'(tile_o.op), 32'(exp_d.op));
        check_val("tile_o.fmt", 32'(tile_o.fmt), 32'(exp_d.fmt));
        check_val("job_done_o", 32'(job_done_o), 32'(last_tile));
        tiles_seen++;
        if (last_tile) begin
          void'(cnt_q.pop_front());
          jobs_done++;
        end
      end else if (job_done_o) begin
        assert (cnt_q.size() > 0 && cnt_q[0] == 0) else
          fail_now($sformatf("job_done_o pulsed at %0t ns with descriptors still owed", $time));
        void'(cnt_q.pop_front());
        jobs_done++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, a job or handshake never finished", TIMEOUT_NS);
    $display("Checks failed");
    $fatal(1);
  end

  initial begin
    size_t m;
    size_t k;
    size_t n;
    int    done_before;
    int    seen_before;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_req_i   = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Exact multiples of the tile sizes
    run_job(16'd16, 16'd12, 16'd32, 32'h1000, 32'h2000, 32'h3000, encode_arith(3'd1, 3'd2));
    wait_idle();

    // Random sizes off the tile grid, edges get clipped
    repeat (4) begin
      m = size_t'(4 * rand_below(6) + 1 + rand_below(3));
      n = size_t'(8 * rand_below(5) + 1 + rand_below(7));
      k = size_t'(1 + rand_below(100));
      run_job(m, k, n, addr_t'($random(seed)), addr_t'($random(seed)),
              addr_t'($random(seed)), encode_arith(op_t'(rand_below(8)), fmt_t'(rand_below(8))));
      wait_idle();
    end

    // Empty jobs
    run_job(16'd0, 16'd5, 16'd16, 32'h100, 32'h200, 32'h300, encode_arith(3'd2, 3'd0));
    wait_idle();
    run_job(16'd8, 16'd5, 16'd0, 32'h400, 32'h500, 32'h600, encode_arith(3'd3, 3'd1));
    wait_idle();

    // Back-pressure, the third arith waits for the first job to end
    done_before = jobs_done;
    run_job(16'd32, 16'd20, 16'd64, 32'h8000, 32'h9000, 32'hA000, encode_arith(3'd4, 3'd3));
    while (!busy_o) @(negedge clk_i);
    run_job(16'd12, 16'd9, 16'd20, 32'hB000, 32'hC000, 32'hD000, encode_arith(3'd5, 3'd4));
    check_val("busy_o", 32'(busy_o), 32'd1);
    build_expected(32'hE000, 32'hE800, 32'hF000, 16'd12, 16'd9, 16'd20, encode_arith(3'd6, 3'd5));
    issue_instr(encode_arith(3'd6, 3'd5), 32'hE000, 32'hE800, 32'hF000);
    assert (jobs_done >= done_before + 1) else
      fail_now("The third arith was taken before the first job had finished");
    wait_idle();

    // Foreign opcode, then an arith reusing the last sizes
    offer_unknown();
    build_expected(32'h1100, 32'h2200, 32'h3300, 16'd12, 16'd9, 16'd20, encode_arith(3'd7, 3'd6));
    issue_instr(encode_arith(3'd7, 3'd6), 32'h1100, 32'h2200, 32'h3300);
    wait_idle();

    // Clear in the middle of a job
    seen_before = tiles_seen;
    run_job(16'd32, 16'd20, 16'd64, 32'h4000, 32'h5000, 32'h6000, encode_arith(3'd1, 3'd1));
    while (tiles_seen < seen_before + 5) @(negedge clk_i);
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    exp_q.delete();
    cnt_q.delete();
    repeat (4) begin
      check_val("busy_o", 32'(busy_o), 32'd0);
      check_val("tile_valid_o", 32'(tile_valid_o), 32'd0);
      @(negedge clk_i);
    end

    // Sizes were zeroed, so an arith alone gives an empty job
    build_expected(32'h7000, 32'h7100, 32'h7200, 16'd0, 16'd0, 16'd0, encode_arith(3'd2, 3'd2));
    issue_instr(encode_arith(3'd2, 3'd2), 32'h7000, 32'h7100, 32'h7200);
    wait_idle();

    repeat (4) @(negedge clk_i);
    if (exp_q.size() == 0 && cnt_q.size() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_now("Expected descriptors were never produced");
    end
  end

endmodule

/* verilog.f */
+incdir+tests
source/xif_pkg.sv
source/accel_pkg.sv
source/inst_decoder.sv
source/ctrl_regfile.sv
source/tile_scheduler.sv
source/accel_top.sv
tests/tb_accel.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
  --top-module tb_accel -o tb_accel

./obj_dir/tb_accel > sim.log 2>&1 || true
cat sim.log

if grep -q "^All checks passed$" sim.log; then
  exit 0
fi
exit 1
